// File: dma_core_top.f
design/dma_pkg.sv
design/dma_reg_frontend.sv
design/dma_job_fifo.sv
design/dma_nd_midend.sv
design/dma_backend.sv
design/dma_id_tracker.sv
design/dma_core_top.sv
tb/dma_mem_model.sv
tb/dma_core_tb.sv

// File: Makefile
# Verilator build and run for the DMA core testbench

VERILATOR ?= verilator
TOP       ?= dma_core_tb
FILELIST  ?= dma_core_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= tests failed
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "all tests passed" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/dma_core_tb.sv
// ******************************
// dma core testbench with a shadow memory image
// ******************************
`timescale 1ns/1ps

module dma_core_tb import dma_pkg::*; ();

  localparam int unsigned MemWords      = 1024;
  localparam int unsigned TotalWords    = 24 + 24 + 6 * 12;
  localparam int unsigned TimeoutCycles = 20 * TotalWords + 2000;

  logic        clk;
  logic        rst_n;
  logic        reg_valid;
  logic        reg_we;
  logic [5:0]  reg_addr;
  logic [31:0] reg_wdata;
  logic        reg_ready;
  logic        reg_rvalid;
  logic [31:0] reg_rdata;
  logic        mem_req;
  logic        mem_we;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic        mem_gnt;
  logic        mem_rvalid;
  logic [31:0] mem_rdata;
  logic        busy;

  logic [31:0] shadow [MemWords];
  int unsigned errors = 0;
  int unsigned cycles = 0;
  int unsigned ready_stalls = 0;
  logic [31:0] expect_id;
  logic [31:0] cfg_src;
  logic [31:0] cfg_dst;
  logic [15:0] cfg_shape;
  logic [31:0] cfg_src_stride;
  logic [31:0] cfg_dst_stride;
  logic        cfg_two_d;
  event        compare_ev;

  dma_core_top #(
    .AddrWidth ( 32 ),
    .FifoDepth ( 4  )
  ) uut (
    .clk_i        ( clk        ),
    .rst_n_i      ( rst_n      ),
    .reg_valid_i  ( reg_valid  ),
    .reg_we_i     ( reg_we     ),
    .reg_addr_i   ( reg_addr   ),
    .reg_wdata_i  ( reg_wdata  ),
    .reg_ready_o  ( reg_ready  ),
    .reg_rvalid_o ( reg_rvalid ),
    .reg_rdata_o  ( reg_rdata  ),
    .mem_req_o    ( mem_req    ),
    .mem_we_o     ( mem_we     ),
    .mem_addr_o   ( mem_addr   ),
    .mem_wdata_o  ( mem_wdata  ),
    .mem_gnt_i    ( mem_gnt    ),
    .mem_rvalid_i ( mem_rvalid ),
    .mem_rdata_i  ( mem_rdata  ),
    .busy_o       ( busy       )
  );

  dma_mem_model #(
    .Words ( MemWords )
  ) i_mem (
    .clk_i    ( clk        ),
    .rst_n_i  ( rst_n      ),
    .req_i    ( mem_req    ),
    .we_i     ( mem_we     ),
    .addr_i   ( mem_addr   ),
    .wdata_i  ( mem_wdata  ),
    .gnt_o    ( mem_gnt    ),
    .rvalid_o ( mem_rvalid ),
    .rdata_o  ( mem_rdata  )
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("timeout: the DMA did not finish within %0d cycles", TimeoutCycles);
      $display("checks done with %0d errors", errors);
      $display("tests failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // expected image with rows copied word by word in issue order
  function automatic void ref_copy(input logic [31:0] src, input logic [31:0] dst,
                                   input logic [15:0] shape, input logic [31:0] src_stride,
                                   input logic [31:0] dst_stride, input logic two_d);
    int unsigned reps;
    int unsigned len;
    logic [31:0] s;
    logic [31:0] d;
    reps = two_d ? 32'(shape[15:8]) : 1;
    len  = two_d ? 32'(shape[7:0]) : 32'(shape);
    for (int unsigned r = 0; r < reps; r++) begin
      for (int unsigned w = 0; w < len; w++) begin
        s = src + r * src_stride + w;
        d = dst + r * dst_stride + w;
        shadow[d % MemWords] = shadow[s % MemWords];
      end
    end
  endfunction

  always @(compare_ev) begin
    for (int i = 0; i < MemWords; i++) begin
      check_value($sformatf("mem[%0d]", i), i_mem.mem_q[i], shadow[i]);
    end
  end

  task automatic reg_access(input logic we, input logic [5:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    @(negedge clk);
    reg_valid = 1'b1;
    reg_we    = we;
    reg_addr  = addr;
    reg_wdata = wdata;
    @(posedge clk);
    while (!reg_ready) begin
      ready_stalls++;
      @(posedge clk);
    end
    @(negedge clk);
    reg_valid = 1'b0;
    reg_we    = 1'b0;
    rdata     = reg_rdata;
    // read data follows a read one cycle later and never a write
    check_value("reg_rvalid_o", {31'h0, reg_rvalid}, {31'h0, ~we});
  endtask

  task automatic reg_write(input logic [5:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    reg_access(1'b1, addr, data, unused);
  endtask

  task automatic reg_read(input logic [5:0] addr, output logic [31:0] data);
    reg_access(1'b0, addr, 32'h0, data);
  endtask

  task automatic configure(input logic [31:0] src, input logic [31:0] dst,
                           input logic [15:0] shape, input logic [31:0] src_stride,
                           input logic [31:0] dst_stride, input logic two_d);
    cfg_src        = src;
    cfg_dst        = dst;
    cfg_shape      = shape;
    cfg_src_stride = src_stride;
    cfg_dst_stride = dst_stride;
    cfg_two_d      = two_d;
    reg_write(REG_SRC, src);
    reg_write(REG_DST, dst);
    reg_write(REG_SHAPE, {16'h0, shape});
    reg_write(REG_SRC_STRIDE, src_stride);
    reg_write(REG_DST_STRIDE, dst_stride);
    reg_write(REG_CONF, {31'h0, two_d});
  endtask

  task automatic launch_job(output logic [31:0] id);
    reg_read(REG_NEXT_ID, id);
    check_value("NEXT_ID", id, expect_id);
    expect_id++;
    ref_copy(cfg_src, cfg_dst, cfg_shape, cfg_src_stride, cfg_dst_stride, cfg_two_d);
  endtask

  task automatic wait_done(input logic [31:0] id);
    logic [31:0] done;
    done = '0;
    while (done < id) begin
      reg_read(REG_DONE_ID, done);
    end
    check_value("DONE_ID", done, id);
  endtask

  task automatic check_memory();
    -> compare_ev;
    @(negedge clk);
  endtask

  initial begin
    logic [31:0] rdata;
    logic [31:0] id;
    logic [31:0] first_id;
    rst_n     = 1'b0;
    reg_valid = 1'b0;
    reg_we    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    expect_id = 32'd1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < MemWords; i++) begin
      shadow[i] = i_mem.mem_q[i];
    end

    // idle outputs after reset
    check_value("reg_ready_o", {31'h0, reg_ready}, 32'h1);
    check_value("reg_rvalid_o", {31'h0, reg_rvalid}, 32'h0);
    check_value("mem_req_o", {31'h0, mem_req}, 32'h0);
    check_value("busy_o", {31'h0, busy}, 32'h0);

    // readback, unknown offsets and idle status
    reg_read(REG_STATUS, rdata);
    check_value("STATUS", rdata, 32'h0);
    reg_read(REG_DONE_ID, rdata);
    check_value("DONE_ID", rdata, 32'h0);
    configure(32'h1357_9bdf, 32'h2468_ace0, 16'h0507, 32'h0000_0011, 32'hffff_fff0, 1'b1);
    reg_read(REG_SRC, rdata);
    check_value("SRC", rdata, 32'h1357_9bdf);
    reg_read(REG_DST, rdata);
    check_value("DST", rdata, 32'h2468_ace0);
    reg_read(REG_SHAPE, rdata);
    check_value("SHAPE", rdata, 32'h0000_0507);
    reg_read(REG_SRC_STRIDE, rdata);
    check_value("SRC_STRIDE", rdata, 32'h0000_0011);
    reg_read(REG_DST_STRIDE, rdata);
    check_value("DST_STRIDE", rdata, 32'hffff_fff0);
    reg_read(REG_CONF, rdata);
    check_value("CONF", rdata, 32'h1);
    reg_read(6'h24, rdata);
    check_value("offset 0x24", rdata, 32'h0);
    reg_read(6'h3c, rdata);
    check_value("offset 0x3c", rdata, 32'h0);

    // 1D copy
    configure(32'd100, 32'd300, 16'd24, 32'd0, 32'd0, 1'b0);
    launch_job(id);
    wait_done(id);
    check_memory();

    // 2D copy leaves the destination gaps as they were
    configure(32'd400, 32'd600, 16'h0406, 32'd8, 32'd10, 1'b1);
    launch_job(id);
    wait_done(id);
    check_memory();

    // back to back launches past the FIFO depth
    configure(32'd700, 32'd800, 16'd12, 32'd0, 32'd0, 1'b0);
    first_id = expect_id;
    for (int k = 0; k < 6; k++) begin
      cfg_src = 32'(700 + 12 * k);
      cfg_dst = 32'(800 + 12 * k);
      reg_write(REG_SRC, cfg_src);
      reg_write(REG_DST, cfg_dst);
      launch_job(id);
    end
    if (ready_stalls == 0) begin
      errors++;
      $display("reg_ready_o never stalled while the job queue was full");
    end
    for (logic [31:0] n = first_id; n <= id; n++) begin
      wait_done(n);
    end
    check_memory();
    reg_read(REG_STATUS, rdata);
    check_value("STATUS", rdata, 32'h0);
    check_value("busy_o", {31'h0, busy}, 32'h0);

    // empty shape retires without touching memory
    configure(32'd900, 32'd950, 16'd0, 32'd0, 32'd0, 1'b0);
    launch_job(id);
    wait_done(id);
    check_memory();
    check_value("busy_o", {31'h0, busy}, 32'h0);

    $display("checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: tb/dma_mem_model.sv
// ******************************
// word memory with random grant stalls
// ******************************
`timescale 1ns/1ps

module dma_mem_model #(
  parameter int unsigned Words = 1024
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        req_i,
  input  logic        we_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o
);

  logic [31:0] mem_q [Words];
  logic        gnt_en_q;
  logic [1:0]  lat_q;
  integer      seed;

  initial begin
    seed     = 32'hee42;
    gnt_en_q = 1'b0;
    lat_q    = 2'd0;
    rdata_o  = '0;
    // odd multiplier keeps every word distinct
    for (int i = 0; i < Words; i++) begin
      mem_q[i] = (32'(i) * 32'h9e37_79b1) ^ 32'h5a5a_0000;
    end
  end

  assign gnt_o    = req_i & gnt_en_q;
  assign rvalid_o = (lat_q == 2'd1);

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      gnt_en_q <= 1'b0;
      lat_q    <= 2'd0;
    end else begin
      // about three grants in four
      gnt_en_q <= (($random(seed) & 3) != 0);
      if (lat_q != 2'd0) begin
        lat_q <= lat_q - 2'd1;
      end
      if (gnt_o && !we_i) begin
        rdata_o <= mem_q[addr_i % Words];
        lat_q   <= 2'd1 + 2'($unsigned($random(seed)) % 3);
      end
      if (gnt_o && we_i) begin
        mem_q[addr_i % Words] <= wdata_i;
      end
    end
  end

endmodule

// File: design/dma_core_top.sv
// ******************************
// dma core top from frontend to backend
// ******************************
`timescale 1ns/1ps

module dma_core_top import dma_pkg::*; #(
  parameter int unsigned AddrWidth = dma_pkg::AddrWidth,
  parameter int unsigned FifoDepth = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    reg_valid_i,
  input  logic                    reg_we_i,
  input  logic [RegAddrWidth-1:0] reg_addr_i,
  input  logic [DataWidth-1:0]    reg_wdata_i,
  output logic                    reg_ready_o,
  output logic                    reg_rvalid_o,
  output logic [DataWidth-1:0]    reg_rdata_o,
  output logic                    mem_req_o,
  output logic                    mem_we_o,
  output logic [AddrWidth-1:0]    mem_addr_o,
  output logic [DataWidth-1:0]    mem_wdata_o,
  input  logic                    mem_gnt_i,
  input  logic                    mem_rvalid_i,
  input  logic [DataWidth-1:0]    mem_rdata_i,
  output logic                    busy_o
);

  logic [JobWidth-1:0]   fe_job;
  logic                  fe_job_valid;
  logic                  fe_job_ready;
  logic [JobWidth-1:0]   me_job;
  logic                  me_job_valid;
  logic                  me_job_ready;
  logic                  fifo_empty;
  logic [AddrWidth-1:0]  burst_src;
  logic [AddrWidth-1:0]  burst_dst;
  logic [ShapeWidth-1:0] burst_len;
  logic                  burst_valid;
  logic                  burst_ready;
  logic                  burst_done;
  logic                  job_done;
  logic                  me_busy;
  logic                  issue;
  logic [IdWidth-1:0]    next_id;
  logic [IdWidth-1:0]    done_id;

  assign issue  = fe_job_valid & fe_job_ready;
  assign busy_o = ~fifo_empty | me_busy;

  dma_reg_frontend i_frontend (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .reg_valid_i  ( reg_valid_i  ),
    .reg_we_i     ( reg_we_i     ),
    .reg_addr_i   ( reg_addr_i   ),
    .reg_wdata_i  ( reg_wdata_i  ),
    .reg_ready_o  ( reg_ready_o  ),
    .reg_rvalid_o ( reg_rvalid_o ),
    .reg_rdata_o  ( reg_rdata_o  ),
    .job_o        ( fe_job       ),
    .job_valid_o  ( fe_job_valid ),
    .job_ready_i  ( fe_job_ready ),
    .next_id_i    ( next_id      ),
    .done_id_i    ( done_id      ),
    .busy_i       ( busy_o       )
  );

  dma_job_fifo #(
    .FifoDepth ( FifoDepth )
  ) i_job_fifo (
    .clk_i   ( clk_i        ),
    .rst_n_i ( rst_n_i      ),
    .data_i  ( fe_job       ),
    .valid_i ( fe_job_valid ),
    .ready_o ( fe_job_ready ),
    .data_o  ( me_job       ),
    .valid_o ( me_job_valid ),
    .ready_i ( me_job_ready ),
    .empty_o ( fifo_empty   )
  );

  dma_nd_midend #(
    .AddrWidth ( AddrWidth )
  ) i_midend (
    .clk_i         ( clk_i        ),
    .rst_n_i       ( rst_n_i      ),
    .job_i         ( me_job       ),
    .job_valid_i   ( me_job_valid ),
    .job_ready_o   ( me_job_ready ),
    .burst_src_o   ( burst_src    ),
    .burst_dst_o   ( burst_dst    ),
    .burst_len_o   ( burst_len    ),
    .burst_valid_o ( burst_valid  ),
    .burst_ready_i ( burst_ready  ),
    .burst_done_i  ( burst_done   ),
    .job_done_o    ( job_done     ),
    .busy_o        ( me_busy      )
  );

  dma_backend #(
    .AddrWidth ( AddrWidth )
  ) i_backend (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .src_i        ( burst_src    ),
    .dst_i        ( burst_dst    ),
    .len_i        ( burst_len    ),
    .valid_i      ( burst_valid  ),
    .ready_o      ( burst_ready  ),
    .done_o       ( burst_done   ),
    .mem_req_o    ( mem_req_o    ),
    .mem_we_o     ( mem_we_o     ),
    .mem_addr_o   ( mem_addr_o   ),
    .mem_wdata_o  ( mem_wdata_o  ),
    .mem_gnt_i    ( mem_gnt_i    ),
    .mem_rvalid_i ( mem_rvalid_i ),
    .mem_rdata_i  ( mem_rdata_i  )
  );

  dma_id_tracker i_id_tracker (
    .clk_i     ( clk_i    ),
    .rst_n_i   ( rst_n_i  ),
    .issue_i   ( issue    ),
    .retire_i  ( job_done ),
    .next_id_o ( next_id  ),
    .done_id_o ( done_id  )
  );

endmodule

// File: design/dma_id_tracker.sv
// ******************************
// transfer id counters
// ******************************
`timescale 1ns/1ps

module dma_id_tracker import dma_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               issue_i,
  input  logic               retire_i,
  output logic [IdWidth-1:0] next_id_o,
  output logic [IdWidth-1:0] done_id_o
);

  logic [IdWidth-1:0] next_q;
  logic [IdWidth-1:0] done_q;

  // ids start at 1 so that done_id of 0 means nothing finished
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      next_q <= IdWidth'(1);
      done_q <= '0;
    end else begin
      if (issue_i) begin
        next_q <= next_q + 1'b1;
      end
      // jobs retire in order
      if (retire_i) begin
        done_q <= done_q + 1'b1;
      end
    end
  end

  assign next_id_o = next_q;
  assign done_id_o = done_q;

endmodule

// File: design/dma_backend.sv
// ******************************
// word copy engine on one memory port
// ******************************
`timescale 1ns/1ps

module dma_backend import dma_pkg::*; #(
  parameter int unsigned AddrWidth = dma_pkg::AddrWidth
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [AddrWidth-1:0]  src_i,
  input  logic [AddrWidth-1:0]  dst_i,
  input  logic [ShapeWidth-1:0] len_i,
  input  logic                  valid_i,
  output logic                  ready_o,
  output logic                  done_o,
  output logic                  mem_req_o,
  output logic                  mem_we_o,
  output logic [AddrWidth-1:0]  mem_addr_o,
  output logic [DataWidth-1:0]  mem_wdata_o,
  input  logic                  mem_gnt_i,
  input  logic                  mem_rvalid_i,
  input  logic [DataWidth-1:0]  mem_rdata_i
);

  localparam logic [1:0] StIdle     = 2'd0;
  localparam logic [1:0] StRead     = 2'd1;
  localparam logic [1:0] StWaitData = 2'd2;
  localparam logic [1:0] StWrite    = 2'd3;

  logic [1:0]            state_q;
  logic [AddrWidth-1:0]  rd_addr_q;
  logic [AddrWidth-1:0]  wr_addr_q;
  logic [ShapeWidth-1:0] left_q;
  logic [DataWidth-1:0]  buf_q;
  logic                  last_word;

  assign last_word = (left_q == ShapeWidth'(1));
  assign ready_o   = (state_q == StIdle);
  assign done_o    = (state_q == StWrite) & mem_gnt_i & last_word;

  // request stays put until granted since it only depends on registers
  assign mem_req_o   = (state_q == StRead) | (state_q == StWrite);
  assign mem_we_o    = (state_q == StWrite);
  assign mem_addr_o  = (state_q == StWrite) ? wr_addr_q : rd_addr_q;
  assign mem_wdata_o = buf_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= StIdle;
    end else begin
      case (state_q)
        StIdle: begin
          if (valid_i) begin
            state_q <= StRead;
          end
        end
        StRead: begin
          if (mem_gnt_i) begin
            state_q <= StWaitData;
          end
        end
        StWaitData: begin
          if (mem_rvalid_i) begin
            state_q <= StWrite;
          end
        end
        StWrite: begin
          if (mem_gnt_i) begin
            state_q <= last_word ? StIdle : StRead;
          end
        end
        default: state_q <= StIdle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == StIdle && valid_i) begin
      rd_addr_q <= src_i;
      wr_addr_q <= dst_i;
      left_q    <= len_i;
    end else if (state_q == StWrite && mem_gnt_i) begin
      rd_addr_q <= rd_addr_q + 1'b1;
      wr_addr_q <= wr_addr_q + 1'b1;
      left_q    <= left_q - 1'b1;
    end
  end

  // one word in flight at a time
  always_ff @(posedge clk_i) begin
    if (state_q == StWaitData && mem_rvalid_i) begin
      buf_q <= mem_rdata_i;
    end
  end

endmodule

// File: design/dma_nd_midend.sv
// ******************************
// 2D job to row bursts
// ******************************
`timescale 1ns/1ps

module dma_nd_midend import dma_pkg::*; #(
  parameter int unsigned AddrWidth = dma_pkg::AddrWidth
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [JobWidth-1:0]   job_i,
  input  logic                  job_valid_i,
  output logic                  job_ready_o,
  output logic [AddrWidth-1:0]  burst_src_o,
  output logic [AddrWidth-1:0]  burst_dst_o,
  output logic [ShapeWidth-1:0] burst_len_o,
  output logic                  burst_valid_o,
  input  logic                  burst_ready_i,
  input  logic                  burst_done_i,
  output logic                  job_done_o,
  output logic                  busy_o
);

  localparam logic [1:0] StIdle  = 2'd0;
  localparam logic [1:0] StIssue = 2'd1;
  localparam logic [1:0] StWait  = 2'd2;

  logic [DataWidth-1:0]  job_src;
  logic [DataWidth-1:0]  job_dst;
  dma_shape_u            job_shape;
  logic [DataWidth-1:0]  job_src_stride;
  logic [DataWidth-1:0]  job_dst_stride;
  logic                  job_two_d;
  logic [ShapeWidth-1:0] len_d;
  logic [7:0]            reps_d;

  logic [1:0]            state_q;
  logic [AddrWidth-1:0]  src_q;
  logic [AddrWidth-1:0]  dst_q;
  logic [AddrWidth-1:0]  src_stride_q;
  logic [AddrWidth-1:0]  dst_stride_q;
  logic [ShapeWidth-1:0] len_q;
  logic [7:0]            rows_left_q;
  logic                  done_q;

  assign {job_src, job_dst, job_shape, job_src_stride, job_dst_stride, job_two_d} = job_i;

  always_comb begin
    if (job_two_d) begin
      len_d  = ShapeWidth'(job_shape.shape_2d.row_len);
      reps_d = job_shape.shape_2d.reps;
    end else begin
      // 1D is a single row
      len_d  = job_shape.len_1d;
      reps_d = 8'd1;
    end
  end

  assign job_ready_o   = (state_q == StIdle);
  assign burst_valid_o = (state_q == StIssue);
  assign burst_src_o   = src_q;
  assign burst_dst_o   = dst_q;
  assign burst_len_o   = len_q;
  assign job_done_o    = done_q;
  assign busy_o        = (state_q != StIdle) | done_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= StIdle;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        StIdle: begin
          if (job_valid_i) begin
            // empty shape retires at once
            if (len_d == '0 || reps_d == '0) begin
              done_q <= 1'b1;
            end else begin
              state_q <= StIssue;
            end
          end
        end
        StIssue: begin
          if (burst_ready_i) begin
            state_q <= StWait;
          end
        end
        StWait: begin
          if (burst_done_i) begin
            if (rows_left_q == 8'd1) begin
              state_q <= StIdle;
              done_q  <= 1'b1;
            end else begin
              state_q <= StIssue;
            end
          end
        end
        default: state_q <= StIdle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == StIdle && job_valid_i) begin
      src_q        <= AddrWidth'(job_src);
      dst_q        <= AddrWidth'(job_dst);
      src_stride_q <= AddrWidth'(job_src_stride);
      dst_stride_q <= AddrWidth'(job_dst_stride);
      len_q        <= len_d;
      rows_left_q  <= reps_d;
    end else if (state_q == StWait && burst_done_i) begin
      // next row
      src_q       <= src_q + src_stride_q;
      dst_q       <= dst_q + dst_stride_q;
      rows_left_q <= rows_left_q - 1'b1;
    end
  end

endmodule

// File: design/dma_job_fifo.sv
// ******************************
// job queue with valid/ready on both sides
// ******************************
`timescale 1ns/1ps

module dma_job_fifo import dma_pkg::*; #(
  parameter int unsigned FifoDepth = 4
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic [JobWidth-1:0] data_i,
  input  logic                valid_i,
  output logic                ready_o,
  output logic [JobWidth-1:0] data_o,
  output logic                valid_o,
  input  logic                ready_i,
  output logic                empty_o
);

  localparam int unsigned PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int unsigned CntWidth = $clog2(FifoDepth + 1);

  logic [JobWidth-1:0] mem_q [FifoDepth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                push;
  logic                pop;

  assign empty_o = (count_q == '0);
  assign valid_o = ~empty_o;
  // full still takes a push when the head leaves this cycle
  assign ready_o = (count_q != CntWidth'(FifoDepth)) | ready_i;
  assign data_o  = mem_q[rd_ptr_q];
  assign push    = valid_i & ready_o;
  assign pop     = valid_o & ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(FifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(FifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// File: design/dma_reg_frontend.sv
// ******************************
// register file, access decode and job launch
// ******************************
`timescale 1ns/1ps

module dma_reg_frontend import dma_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    reg_valid_i,
  input  logic                    reg_we_i,
  input  logic [RegAddrWidth-1:0] reg_addr_i,
  input  logic [DataWidth-1:0]    reg_wdata_i,
  output logic                    reg_ready_o,
  output logic                    reg_rvalid_o,
  output logic [DataWidth-1:0]    reg_rdata_o,
  output logic [JobWidth-1:0]     job_o,
  output logic                    job_valid_o,
  input  logic                    job_ready_i,
  input  logic [IdWidth-1:0]      next_id_i,
  input  logic [IdWidth-1:0]      done_id_i,
  input  logic                    busy_i
);

  logic [DataWidth-1:0] src_q;
  logic [DataWidth-1:0] dst_q;
  dma_shape_u           shape_q;
  logic [DataWidth-1:0] src_stride_q;
  logic [DataWidth-1:0] dst_stride_q;
  logic                 two_d_q;
  logic                 next_id_rd;
  logic                 wr_acc;
  logic                 rd_acc;
  logic [DataWidth-1:0] rdata_d;
  logic [DataWidth-1:0] rdata_q;
  logic                 rvalid_q;

  // reading NEXT_ID is what launches a job
  assign next_id_rd  = reg_valid_i & ~reg_we_i & (reg_addr_i == REG_NEXT_ID);
  assign job_valid_o = next_id_rd;
  assign job_o       = {src_q, dst_q, shape_q, src_stride_q, dst_stride_q, two_d_q};
  assign reg_ready_o = ~next_id_rd | job_ready_i;

  assign wr_acc = reg_valid_i & reg_ready_o & reg_we_i;
  assign rd_acc = reg_valid_i & reg_ready_o & ~reg_we_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      src_q        <= '0;
      dst_q        <= '0;
      shape_q      <= '0;
      src_stride_q <= '0;
      dst_stride_q <= '0;
      two_d_q      <= 1'b0;
    end else if (wr_acc) begin
      case (reg_addr_i)
        REG_SRC:        src_q        <= reg_wdata_i;
        REG_DST:        dst_q        <= reg_wdata_i;
        REG_SHAPE:      shape_q      <= reg_wdata_i[ShapeWidth-1:0];
        REG_SRC_STRIDE: src_stride_q <= reg_wdata_i;
        REG_DST_STRIDE: dst_stride_q <= reg_wdata_i;
        REG_CONF:       two_d_q      <= reg_wdata_i[0];
        default: ;
      endcase
    end
  end

  always_comb begin
    case (reg_addr_i)
      REG_SRC:        rdata_d = src_q;
      REG_DST:        rdata_d = dst_q;
      REG_SHAPE:      rdata_d = DataWidth'(shape_q);
      REG_SRC_STRIDE: rdata_d = src_stride_q;
      REG_DST_STRIDE: rdata_d = dst_stride_q;
      REG_CONF:       rdata_d = DataWidth'(two_d_q);
      REG_NEXT_ID:    rdata_d = DataWidth'(next_id_i);
      REG_DONE_ID:    rdata_d = DataWidth'(done_id_i);
      REG_STATUS:     rdata_d = DataWidth'(busy_i);
      default:        rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd_acc;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_acc) begin
      rdata_q <= rdata_d;
    end
  end

  assign reg_rvalid_o = rvalid_q;
  assign reg_rdata_o  = rdata_q;

endmodule

// File: design/dma_pkg.sv
// ******************************
// widths, register map and the shape word
// ******************************
package dma_pkg;

  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned IdWidth      = 32;
  localparam int unsigned RegAddrWidth = 6;
  localparam int unsigned ShapeWidth   = 16;

  // register offsets
  localparam logic [RegAddrWidth-1:0] REG_SRC        = 6'h00;
  localparam logic [RegAddrWidth-1:0] REG_DST        = 6'h04;
  localparam logic [RegAddrWidth-1:0] REG_SHAPE      = 6'h08;
  localparam logic [RegAddrWidth-1:0] REG_SRC_STRIDE = 6'h0C;
  localparam logic [RegAddrWidth-1:0] REG_DST_STRIDE = 6'h10;
  localparam logic [RegAddrWidth-1:0] REG_CONF       = 6'h14;
  localparam logic [RegAddrWidth-1:0] REG_NEXT_ID    = 6'h18;
  localparam logic [RegAddrWidth-1:0] REG_DONE_ID    = 6'h1C;
  localparam logic [RegAddrWidth-1:0] REG_STATUS     = 6'h20;

  // one word read two ways by the job's two_d bit
  typedef union packed {
    logic [ShapeWidth-1:0] len_1d;
    struct packed {
      logic [7:0] reps;
      logic [7:0] row_len;
    } shape_2d;
  } dma_shape_u;

  // src, dst, shape, src_stride, dst_stride, two_d
  localparam int unsigned JobWidth = 4 * DataWidth + ShapeWidth + 1;

endpackage
